// File: Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_wb_alu_core
FLIST = src.f
BUILD = obj_dir

.PHONY: sim clean

# The run passes only when the pass message shows up in the output
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | awk '{print} /All tests passed!/ {ok = 1} END {exit !ok}'

clean:
	rm -rf $(BUILD)

// File: source/alu_execute.sv
`timescale 1ns/10ps

module alu_execute import core_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     ex_valid_i,
    input  alu_op_t  ex_op_i,
    input  word_t    ex_a_i,
    input  word_t    ex_b_i,
    input  logic     ex_wreg_i,
    input  reg_idx_t ex_wd_i,
    // Back to decode
    output logic     ex_fwd_wreg_o,
    output reg_idx_t ex_fwd_wd_o,
    output word_t    ex_fwd_data_o,
    // To result stage
    output logic     res_valid_o,
    output logic     res_wreg_o,
    output reg_idx_t res_wd_o,
    output word_t    res_data_o
);

    word_t alu_result;

    always_comb begin
        case (ex_op_i)
            ALU_OR:   alu_result = ex_a_i | ex_b_i;
            ALU_AND:  alu_result = ex_a_i & ex_b_i;
            ALU_XOR:  alu_result = ex_a_i ^ ex_b_i;
            ALU_NOR:  alu_result = ~(ex_a_i | ex_b_i);
            // Shifts move b by the low bits of a
            ALU_SLL:  alu_result = ex_b_i << ex_a_i[4:0];
            ALU_SRL:  alu_result = ex_b_i >> ex_a_i[4:0];
            ALU_SRA:  alu_result = word_t'($signed(ex_b_i) >>> ex_a_i[4:0]);
            ALU_ADD:  alu_result = ex_a_i + ex_b_i;
            ALU_SUB:  alu_result = ex_a_i - ex_b_i;
            ALU_SLT:  alu_result = {31'd0, $signed(ex_a_i) < $signed(ex_b_i)};
            ALU_SLTU: alu_result = {31'd0, ex_a_i < ex_b_i};
            ALU_PASS: alu_result = ex_a_i;
            default:  alu_result = '0;
        endcase
    end

    // Unregistered result seen by decode in the same cycle
    assign ex_fwd_wreg_o = ex_valid_i && ex_wreg_i;
    assign ex_fwd_wd_o   = ex_wd_i;
    assign ex_fwd_data_o = alu_result;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_valid_o <= 1'b0;
            res_wreg_o  <= 1'b0;
        end else begin
            res_valid_o <= ex_valid_i;
            res_wreg_o  <= ex_valid_i && ex_wreg_i;
        end
    end

    always_ff @(posedge clk) begin
        res_wd_o   <= ex_wd_i;
        res_data_o <= alu_result;
    end

endmodule

// File: source/core_pkg.sv
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  bus_adr_t;

    // Operations understood by the execute stage
    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_OR   = 4'd1,
        ALU_AND  = 4'd2,
        ALU_XOR  = 4'd3,
        ALU_NOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_ADD  = 4'd8,
        ALU_SUB  = 4'd9,
        ALU_SLT  = 4'd10,
        ALU_SLTU = 4'd11,
        ALU_PASS = 4'd12
    } alu_op_t;

    // Instruction words are written here
    localparam bus_adr_t INST_ADR = 8'h80;

    // General registers read back at byte address 4*k
    localparam int NUM_REGS = 32;

endpackage

// File: source/inst_decode.sv
`timescale 1ns/10ps

module inst_decode import mips_isa_pkg::*, core_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     dec_valid_i,
    input  word_t    dec_inst_i,
    output reg_idx_t rd_idx_a_o,
    output reg_idx_t rd_idx_b_o,
    input  word_t    rd_data_a_i,
    input  word_t    rd_data_b_i,
    // From execute
    input  logic     ex_fwd_wreg_i,
    input  reg_idx_t ex_fwd_wd_i,
    input  word_t    ex_fwd_data_i,
    // From result
    input  logic     res_fwd_wreg_i,
    input  reg_idx_t res_fwd_wd_i,
    input  word_t    res_fwd_data_i,
    // To execute
    output logic     ex_valid_o,
    output alu_op_t  ex_op_o,
    output word_t    ex_a_o,
    output word_t    ex_b_o,
    output logic     ex_wreg_o,
    output reg_idx_t ex_wd_o
);

    opcode_t  op;
    funct_t   funct;
    shamt_t   shamt;
    imm16_t   imm16;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;

    alu_op_t  op_d;
    logic     read_a;
    logic     read_b;
    logic     wreg_d;
    logic     is_movn;
    logic     is_movz;
    logic     wreg_ok;
    reg_idx_t wd_d;
    word_t    imm;
    word_t    opnd_a;
    word_t    opnd_b;

    assign op    = dec_inst_i[31:26];
    assign rs    = dec_inst_i[25:21];
    assign rt    = dec_inst_i[20:16];
    assign rd    = dec_inst_i[15:11];
    assign shamt = dec_inst_i[10:6];
    assign funct = dec_inst_i[5:0];
    assign imm16 = dec_inst_i[15:0];

    assign rd_idx_a_o = rs;
    assign rd_idx_b_o = rt;

    always_comb begin
        op_d    = ALU_NOP;
        read_a  = 1'b1;
        read_b  = 1'b1;
        wd_d    = rd;
        imm     = '0;
        is_movn = 1'b0;
        is_movz = 1'b0;
        case (op)
            OP_SPECIAL: begin
                case (funct)
                    FN_OR:            op_d = ALU_OR;
                    FN_AND:           op_d = ALU_AND;
                    FN_XOR:           op_d = ALU_XOR;
                    FN_NOR:           op_d = ALU_NOR;
                    FN_SLLV:          op_d = ALU_SLL;
                    FN_SRLV:          op_d = ALU_SRL;
                    FN_SRAV:          op_d = ALU_SRA;
                    FN_ADD, FN_ADDU:  op_d = ALU_ADD;
                    FN_SUB, FN_SUBU:  op_d = ALU_SUB;
                    FN_SLT:           op_d = ALU_SLT;
                    FN_SLTU:          op_d = ALU_SLTU;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        // Shift amount comes in as operand a
                        op_d   = (funct == FN_SLL) ? ALU_SLL :
                                 (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                        read_a = 1'b0;
                        imm    = {27'd0, shamt};
                    end
                    FN_MOVN: begin
                        op_d    = ALU_PASS;
                        is_movn = 1'b1;
                    end
                    FN_MOVZ: begin
                        op_d    = ALU_PASS;
                        is_movz = 1'b1;
                    end
                    default: op_d = ALU_NOP;
                endcase
            end
            OP_ORI: begin
                op_d = ALU_OR;
                imm  = {16'h0000, imm16};
            end
            OP_ANDI: begin
                op_d = ALU_AND;
                imm  = {16'h0000, imm16};
            end
            OP_XORI: begin
                op_d = ALU_XOR;
                imm  = {16'h0000, imm16};
            end
            OP_ADDI, OP_ADDIU: begin
                op_d = ALU_ADD;
                imm  = {{16{imm16[15]}}, imm16};
            end
            OP_SLTI: begin
                op_d = ALU_SLT;
                imm  = {{16{imm16[15]}}, imm16};
            end
            OP_SLTIU: begin
                op_d = ALU_SLTU;
                imm  = {{16{imm16[15]}}, imm16};
            end
            OP_LUI: begin
                // Both operands take the immediate and rs is ignored
                op_d   = ALU_PASS;
                read_a = 1'b0;
                imm    = {imm16, 16'h0000};
            end
            default: op_d = ALU_NOP;
        endcase
        // I-type writes rt and takes the immediate as b
        if (op != OP_SPECIAL) begin
            read_b = 1'b0;
            wd_d   = rt;
        end
        wreg_d = (op_d != ALU_NOP);
    end

    // Youngest producer wins
    function automatic word_t pick_operand(input logic use_reg, input reg_idx_t idx,
                                           input word_t rf_data);
        if (use_reg && ex_fwd_wreg_i && (ex_fwd_wd_i == idx)) begin
            return ex_fwd_data_i;
        end else if (use_reg && res_fwd_wreg_i && (res_fwd_wd_i == idx)) begin
            return res_fwd_data_i;
        end else if (use_reg) begin
            return rf_data;
        end
        return imm;
    endfunction

    always_comb begin
        opnd_a = pick_operand(read_a, rs, rd_data_a_i);
        opnd_b = pick_operand(read_b, rt, rd_data_b_i);
    end

    assign wreg_ok = wreg_d && (wd_d != '0) &&
                     !(is_movn && (opnd_b == '0)) && !(is_movz && (opnd_b != '0));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_valid_o <= 1'b0;
            ex_wreg_o  <= 1'b0;
        end else begin
            ex_valid_o <= dec_valid_i;
            ex_wreg_o  <= dec_valid_i && wreg_ok;
        end
    end

    always_ff @(posedge clk) begin
        ex_op_o <= op_d;
        ex_a_o  <= opnd_a;
        ex_b_o  <= opnd_b;
        ex_wd_o <= wd_d;
    end

endmodule

// File: source/mips_isa_pkg.sv
package mips_isa_pkg;

    // Instruction word fields
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm16_t;

    // Primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;

    // SPECIAL function codes for shifts by shamt
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;

    // Shifts by register
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;

    // Conditional moves
    localparam funct_t FN_MOVZ = 6'b001010;
    localparam funct_t FN_MOVN = 6'b001011;

    // Arithmetic and logic
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

endpackage

// File: source/result_writeback.sv
`timescale 1ns/10ps

module result_writeback import core_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     res_valid_i,
    input  logic     res_wreg_i,
    input  reg_idx_t res_wd_i,
    input  word_t    res_data_i,
    // Pending write forwarded to decode
    output logic     res_fwd_wreg_o,
    output reg_idx_t res_fwd_wd_o,
    output word_t    res_fwd_data_o,
    // Decode read ports
    input  reg_idx_t rd_idx_a_i,
    input  reg_idx_t rd_idx_b_i,
    output word_t    rd_data_a_o,
    output word_t    rd_data_b_o,
    // Host read port
    input  reg_idx_t bus_idx_i,
    output word_t    bus_data_o
);

    word_t regs [NUM_REGS];
    logic  wr_en;

    assign wr_en = res_valid_i && res_wreg_i;

    assign res_fwd_wreg_o = wr_en;
    assign res_fwd_wd_o   = res_wd_i;
    assign res_fwd_data_o = res_data_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[res_wd_i] <= res_data_i;
        end
    end

    // r0 is hardwired to zero
    assign rd_data_a_o = (rd_idx_a_i == '0) ? '0 : regs[rd_idx_a_i];
    assign rd_data_b_o = (rd_idx_b_i == '0) ? '0 : regs[rd_idx_b_i];
    assign bus_data_o  = (bus_idx_i == '0) ? '0 : regs[bus_idx_i];

endmodule

// File: source/wb_alu_core.sv
`timescale 1ns/10ps

module wb_alu_core import core_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    input  bus_adr_t wb_adr_i,
    input  word_t    wb_dat_i,
    output word_t    wb_dat_o,
    output logic     wb_ack_o
);

    logic     dec_valid;
    word_t    dec_inst;
    reg_idx_t rd_idx_a;
    reg_idx_t rd_idx_b;
    word_t    rd_data_a;
    word_t    rd_data_b;
    logic     ex_fwd_wreg;
    reg_idx_t ex_fwd_wd;
    word_t    ex_fwd_data;
    logic     res_fwd_wreg;
    reg_idx_t res_fwd_wd;
    word_t    res_fwd_data;
    logic     ex_valid;
    alu_op_t  ex_op;
    word_t    ex_a;
    word_t    ex_b;
    logic     ex_wreg;
    reg_idx_t ex_wd;
    logic     res_valid;
    logic     res_wreg;
    reg_idx_t res_wd;
    word_t    res_data;
    word_t    bus_data;

    logic     req;
    logic     wr_req;
    logic     rd_req;
    logic     busy;
    logic     rd_mapped;

    // New request only while ack is low, so acks never run back to back
    assign req    = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign busy   = dec_valid || ex_valid || res_valid;
    assign wr_req = req && wb_we_i;
    // Reads wait until the pipeline has drained
    assign rd_req = req && !wb_we_i && !busy;

    assign rd_mapped = (wb_adr_i < bus_adr_t'(NUM_REGS * 4)) && (wb_adr_i[1:0] == 2'b00);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_ack_o  <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            wb_ack_o  <= wr_req || rd_req;
            dec_valid <= wr_req && (wb_adr_i == INST_ADR);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_req) begin
            dec_inst <= wb_dat_i;
        end
        if (rd_req) begin
            wb_dat_o <= rd_mapped ? bus_data : '0;
        end
    end

    inst_decode inst_decode_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .dec_valid_i    (dec_valid),
        .dec_inst_i     (dec_inst),
        .rd_idx_a_o     (rd_idx_a),
        .rd_idx_b_o     (rd_idx_b),
        .rd_data_a_i    (rd_data_a),
        .rd_data_b_i    (rd_data_b),
        .ex_fwd_wreg_i  (ex_fwd_wreg),
        .ex_fwd_wd_i    (ex_fwd_wd),
        .ex_fwd_data_i  (ex_fwd_data),
        .res_fwd_wreg_i (res_fwd_wreg),
        .res_fwd_wd_i   (res_fwd_wd),
        .res_fwd_data_i (res_fwd_data),
        .ex_valid_o     (ex_valid),
        .ex_op_o        (ex_op),
        .ex_a_o         (ex_a),
        .ex_b_o         (ex_b),
        .ex_wreg_o      (ex_wreg),
        .ex_wd_o        (ex_wd)
    );

    alu_execute alu_execute_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .ex_valid_i    (ex_valid),
        .ex_op_i       (ex_op),
        .ex_a_i        (ex_a),
        .ex_b_i        (ex_b),
        .ex_wreg_i     (ex_wreg),
        .ex_wd_i       (ex_wd),
        .ex_fwd_wreg_o (ex_fwd_wreg),
        .ex_fwd_wd_o   (ex_fwd_wd),
        .ex_fwd_data_o (ex_fwd_data),
        .res_valid_o   (res_valid),
        .res_wreg_o    (res_wreg),
        .res_wd_o      (res_wd),
        .res_data_o    (res_data)
    );

    result_writeback result_writeback_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .res_valid_i    (res_valid),
        .res_wreg_i     (res_wreg),
        .res_wd_i       (res_wd),
        .res_data_i     (res_data),
        .res_fwd_wreg_o (res_fwd_wreg),
        .res_fwd_wd_o   (res_fwd_wd),
        .res_fwd_data_o (res_fwd_data),
        .rd_idx_a_i     (rd_idx_a),
        .rd_idx_b_i     (rd_idx_b),
        .rd_data_a_o    (rd_data_a),
        .rd_data_b_o    (rd_data_b),
        .bus_idx_i      (wb_adr_i[6:2]),
        .bus_data_o     (bus_data)
    );

endmodule

// File: src.f
source/mips_isa_pkg.sv
source/core_pkg.sv
source/inst_decode.sv
source/alu_execute.sv
source/result_writeback.sv
source/wb_alu_core.sv
tb/wb_alu_core_chk.sv
tb/tb_wb_alu_core.sv

// File: tb/tb_wb_alu_core.sv
`timescale 1ns/10ps

module tb_wb_alu_core import mips_isa_pkg::*, core_pkg::*; ();

    localparam int ACK_TIMEOUT = 20;

    logic     clk;
    logic     reset_i;
    logic     wb_cyc_i;
    logic     wb_stb_i;
    logic     wb_we_i;
    bus_adr_t wb_adr_i;
    word_t    wb_dat_i;
    word_t    wb_dat_o;
    logic     wb_ack_o;

    word_t    model [NUM_REGS];
    integer   seed;
    int       errors;
    int       checks;

    funct_t   logic_fns [4]  = '{FN_OR, FN_AND, FN_XOR, FN_NOR};
    funct_t   arith_fns [12] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
                                 FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
    opcode_t  imm_ops [4]    = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};

    wb_alu_core wb_alu_core_i (.*);

    always #10 clk = ~clk;

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Error at time %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic word_t rand_word();
        word_t r;
        r = $random(seed);
        return r;
    endfunction

    function automatic reg_idx_t rand_reg();
        word_t r;
        r = rand_word();
        return r[4:0];
    endfunction

    function automatic word_t r_type(input funct_t fn, input reg_idx_t rs, input reg_idx_t rt,
                                     input reg_idx_t rd, input shamt_t sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t i_type(input opcode_t op, input reg_idx_t rs, input reg_idx_t rt,
                                     input imm16_t imm);
        return {op, rs, rt, imm};
    endfunction

    // Reference behavior of one instruction in program order
    function automatic void model_exec(input word_t inst);
        word_t    a;
        word_t    b;
        word_t    sx;
        word_t    res;
        reg_idx_t dst;
        logic     wr;
        a   = model[inst[25:21]];
        b   = model[inst[20:16]];
        sx  = {{16{inst[15]}}, inst[15:0]};
        dst = inst[20:16];
        wr  = 1'b1;
        res = '0;
        if (inst[31:26] == OP_SPECIAL) begin
            dst = inst[15:11];
            case (inst[5:0])
                FN_OR:           res = a | b;
                FN_AND:          res = a & b;
                FN_XOR:          res = a ^ b;
                FN_NOR:          res = ~(a | b);
                FN_SLL:          res = b << inst[10:6];
                FN_SRL:          res = b >> inst[10:6];
                FN_SRA:          res = word_t'($signed(b) >>> inst[10:6]);
                FN_SLLV:         res = b << a[4:0];
                FN_SRLV:         res = b >> a[4:0];
                FN_SRAV:         res = word_t'($signed(b) >>> a[4:0]);
                FN_ADD, FN_ADDU: res = a + b;
                FN_SUB, FN_SUBU: res = a - b;
                FN_SLT:          res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLTU:         res = (a < b) ? 32'd1 : 32'd0;
                FN_MOVN: begin
                    res = a;
                    wr  = (b != 0);
                end
                FN_MOVZ: begin
                    res = a;
                    wr  = (b == 0);
                end
                default:         wr = 1'b0;
            endcase
        end else begin
            case (inst[31:26])
                OP_ORI:            res = a | {16'h0000, inst[15:0]};
                OP_ANDI:           res = a & {16'h0000, inst[15:0]};
                OP_XORI:           res = a ^ {16'h0000, inst[15:0]};
                OP_LUI:            res = {inst[15:0], 16'h0000};
                OP_ADDI, OP_ADDIU: res = a + sx;
                OP_SLTI:           res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
                OP_SLTIU:          res = (a < sx) ? 32'd1 : 32'd0;
                default:           wr = 1'b0;
            endcase
        end
        if (wr && dst != 0) begin
            model[dst] = res;
        end
    endfunction

    task automatic wait_ack(input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_ack_o && cycles < ACK_TIMEOUT);
        if (!wb_ack_o) begin
            $display("Timeout: the bus %s got no ack within %0d cycles", what, ACK_TIMEOUT);
            errors++;
            finish_run();
        end
    endtask

    task automatic bus_idle();
        @(negedge clk);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    // With hold set, stb stays high into the next request
    task automatic bus_write(input bus_adr_t adr, input word_t dat, input logic hold);
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wait_ack("write");
        if (!hold) begin
            bus_idle();
        end
    endtask

    task automatic bus_read(input bus_adr_t adr, output word_t dat);
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = adr;
        wait_ack("read");
        dat = wb_dat_o;
        bus_idle();
    endtask

    task automatic issue(input word_t inst, input logic hold);
        model_exec(inst);
        bus_write(INST_ADR, inst, hold);
    endtask

    task automatic read_reg_check(input reg_idx_t k);
        word_t val;
        bus_read(bus_adr_t'({k, 2'b00}), val);
        check_value($sformatf("wb_dat_o(r%0d)", k), val, model[k]);
    endtask

    task automatic check_all_regs();
        for (int k = 0; k < NUM_REGS; k++) begin
            read_reg_check(reg_idx_t'(k));
        end
    endtask

    initial begin
        word_t    r;
        word_t    val;
        reg_idx_t prev;
        reg_idx_t prev2;
        reg_idx_t dst;
        clk      = 1'b0;
        reset_i  = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        seed     = 2;
        errors   = 0;
        checks   = 0;
        for (int k = 0; k < NUM_REGS; k++) begin
            model[k] = '0;
        end
        repeat (8) @(negedge clk);
        reset_i = 1'b0;

        check_all_regs();

        // Random register contents before the logic and immediate forms
        for (int k = 1; k < NUM_REGS; k++) begin
            issue(i_type(OP_LUI, 5'd0, reg_idx_t'(k), imm16_t'(rand_word() >> 16)), 1'b0);
            issue(i_type(OP_ORI, reg_idx_t'(k), reg_idx_t'(k), imm16_t'(rand_word() >> 16)),
                  1'b0);
        end
        for (int n = 0; n < 40; n++) begin
            r = rand_word();
            case (r[2:0])
                3'd4:    issue(i_type(OP_ORI, rand_reg(), rand_reg(), r[31:16]), 1'b0);
                3'd5:    issue(i_type(OP_ANDI, rand_reg(), rand_reg(), r[31:16]), 1'b0);
                3'd6:    issue(i_type(OP_XORI, rand_reg(), rand_reg(), r[31:16]), 1'b0);
                3'd7:    issue(i_type(OP_LUI, rand_reg(), rand_reg(), r[31:16]), 1'b0);
                default: issue(r_type(logic_fns[r[4:3]], rand_reg(), rand_reg(), rand_reg(),
                                      r[10:6]), 1'b0);
            endcase
        end
        check_all_regs();

        // Dependent chain with stb held high the whole way
        prev  = 5'd1;
        prev2 = 5'd2;
        for (int n = 0; n < 24; n++) begin
            r   = rand_word();
            dst = rand_reg();
            if (r[0]) begin
                issue(r_type(arith_fns[int'(r % 32'd12)], prev, prev2, dst, r[10:6]), 1'b1);
            end else begin
                issue(r_type(logic_fns[r[2:1]], prev, prev2, dst, r[10:6]), 1'b1);
            end
            prev2 = prev;
            prev  = dst;
        end
        bus_idle();
        check_all_regs();

        // Shifts, add and sub, set-less-than with negative operands
        issue(i_type(OP_LUI, 5'd0, 5'd3, 16'h8000), 1'b0);
        issue(i_type(OP_ADDIU, 5'd0, 5'd4, 16'hfff0), 1'b0);
        for (int n = 0; n < 40; n++) begin
            r = rand_word();
            if (r[31]) begin
                issue(i_type(imm_ops[r[1:0]], rand_reg(), rand_reg(), r[23:8]), 1'b0);
            end else begin
                issue(r_type(arith_fns[int'(r % 32'd12)], rand_reg(), rand_reg(), rand_reg(),
                             r[12:8]), 1'b0);
            end
        end
        check_all_regs();

        // Conditional moves, r0 writes, unknown codes, foreign addresses
        issue(i_type(OP_ANDI, 5'd0, 5'd1, 16'h0000), 1'b0);
        issue(i_type(OP_ORI, 5'd0, 5'd2, 16'h1234), 1'b0);
        issue(r_type(FN_MOVN, 5'd4, 5'd1, 5'd3, 5'd0), 1'b0);
        issue(r_type(FN_MOVN, 5'd4, 5'd2, 5'd5, 5'd0), 1'b0);
        issue(r_type(FN_MOVZ, 5'd6, 5'd1, 5'd7, 5'd0), 1'b0);
        issue(r_type(FN_MOVZ, 5'd6, 5'd2, 5'd8, 5'd0), 1'b0);
        for (int n = 0; n < 12; n++) begin
            r = rand_word();
            issue(r_type(r[0] ? FN_MOVN : FN_MOVZ, rand_reg(), r[1] ? 5'd1 : rand_reg(),
                         rand_reg(), 5'd0), 1'b0);
        end
        issue(i_type(OP_ORI, 5'd2, 5'd0, 16'hffff), 1'b0);
        issue(r_type(FN_ADDU, 5'd2, 5'd2, 5'd0, 5'd0), 1'b0);
        issue(i_type(6'b111111, 5'd2, 5'd9, 16'h5555), 1'b0);
        issue(r_type(6'b111111, 5'd2, 5'd2, 5'd10, 5'd0), 1'b0);
        bus_write(8'h84, i_type(OP_ORI, 5'd2, 5'd11, 16'hbeef), 1'b0);
        bus_write(8'h00, i_type(OP_ORI, 5'd2, 5'd12, 16'hbeef), 1'b0);
        check_all_regs();
        bus_read(8'ha0, val);
        check_value("wb_dat_o(0xa0)", val, '0);
        // Misaligned address whose index bits point at r2
        bus_read(8'h0a, val);
        check_value("wb_dat_o(0x0a)", val, '0);

        // Read straight after the write that produces the value
        for (int n = 0; n < 10; n++) begin
            r   = rand_word();
            dst = rand_reg();
            issue(r_type(arith_fns[int'(r % 32'd12)], rand_reg(), rand_reg(), dst, r[12:8]),
                  1'b1);
            read_reg_check(dst);
        end

        finish_run();
    end

endmodule

// File: tb/wb_alu_core_chk.sv
`timescale 1ns/10ps

module wb_alu_core_chk (
    input logic clk,
    input logic reset_i,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_o
);

    // Registered ack lasts exactly one cycle
    ack_single_cycle: assert property (@(posedge clk) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o)
        else $error("wb_ack_o high in two consecutive cycles");

    ack_needs_request: assert property (@(posedge clk) disable iff (reset_i)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i))
        else $error("wb_ack_o high without wb_cyc_i and wb_stb_i");

    ack_low_in_reset: assert property (@(posedge clk)
        reset_i |=> !wb_ack_o)
        else $error("wb_ack_o high during reset");

endmodule

bind wb_alu_core wb_alu_core_chk wb_alu_core_chk_i (.*);
